// ==== rtl/neuron_macros.svh ====
`ifndef NEURON_MACROS_SVH
`define NEURON_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Neuron geometry
//////////////////////////////////////////////////////////////////////

// Total number of activation and weight lanes.
`define NEURON_INPUTS 15

// Lanes 0 to NEURON_SPLIT-1 go to the low dot product.
// The remaining lanes go to the high one.
`define NEURON_SPLIT 8

//////////////////////////////////////////////////////////////////////
// Output scaling
//////////////////////////////////////////////////////////////////////

// Shift from the accumulator format back to the output format.
`define NEURON_FRAC_BITS 6

// Largest value the output may take.
`define NEURON_OUT_MAX 127

// Cycles from in_valid to out_valid.
`define NEURON_LATENCY 3

`endif

// ==== rtl/neuron_pkg.sv ====
package neuron_pkg;

	// Activations and weights carry 6 fractional bits.
	typedef logic signed [7:0] act_t;

	typedef logic signed [7:0] weight_t;

	// The bias has the same format as an activation.
	// It is shifted left by 6 to line up with the 12 fractional bits of a product.
	typedef logic signed [7:0] bias_t;

	// One lane product, with 12 fractional bits.
	typedef logic signed [15:0] product_t;

	// Wide enough for fifteen worst-case products plus the scaled bias.
	// The same width serves the partial sums and the full sum.
	typedef logic signed [22:0] acc_t;

	// Activated output, after ReLU and saturation.
	typedef logic [7:0] result_t;

endpackage

// ==== rtl/partial_dot.sv ====
`timescale 1ns/1ps

module partial_dot
#(
	parameter int LANES = 8
)
(
	input  logic clk,
	input  logic reset,
	input  neuron_pkg::act_t [LANES-1:0] act,
	input  neuron_pkg::weight_t [LANES-1:0] weight,
	output neuron_pkg::acc_t partial
);

	// Worst product is -128 times -128, which is 2^14.
	localparam int signed PARTIAL_MAX = LANES * (1 << 14);

	neuron_pkg::act_t [LANES-1:0] act_q;
	neuron_pkg::weight_t [LANES-1:0] weight_q;
	neuron_pkg::product_t products [LANES];
	neuron_pkg::acc_t lane_sum;

	//////////////////////////////////////////////////////////////////////
	// Input capture
	//////////////////////////////////////////////////////////////////////

	// Lanes are taken every clock; the strobe travels alongside in relu_quantize.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			act_q <= '0;
			weight_q <= '0;
		end
		else
		begin
			act_q <= act;
			weight_q <= weight;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Multiplier bank and adder tree
	//////////////////////////////////////////////////////////////////////

	genvar g;
	generate
		for (g = 0; g < LANES; g++)
		begin : g_lane
			assign products[g] = $signed(act_q[g]) * $signed(weight_q[g]);
		end
	endgenerate

	// Each product is sign extended before it is added in.
	always_comb
	begin
		lane_sum = '0;
		for (int i = 0; i < LANES; i++)
		begin
			lane_sum = lane_sum + neuron_pkg::acc_t'(products[i]);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			partial <= '0;
		end
		else
		begin
			partial <= lane_sum;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// A partial sum outside this range means the accumulator wrapped.
	a_partial_range: assert property (
		@(posedge clk) disable iff (reset)
		(partial >= -PARTIAL_MAX) && (partial <= PARTIAL_MAX)
	)
	else
		$error("partial_dot: partial sum %0d out of range", partial);

endmodule

// ==== rtl/relu_quantize.sv ====
`timescale 1ns/1ps

`include "neuron_macros.svh"

module relu_quantize
(
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  neuron_pkg::bias_t bias,
	input  neuron_pkg::acc_t partial_low,
	input  neuron_pkg::acc_t partial_high,
	output neuron_pkg::result_t out,
	output logic out_valid
);

	localparam int ACC_W = $bits(neuron_pkg::acc_t);
	localparam int FRAC = `NEURON_FRAC_BITS;
	localparam int ROUND_W = ACC_W - FRAC;

	neuron_pkg::bias_t bias_d1;
	neuron_pkg::bias_t bias_d2;
	logic valid_d1;
	logic valid_d2;

	neuron_pkg::acc_t bias_scaled;
	neuron_pkg::acc_t sum_full;
	logic [ROUND_W-1:0] rounded;
	neuron_pkg::result_t act_out;

	//////////////////////////////////////////////////////////////////////
	// Alignment with the dot products
	//////////////////////////////////////////////////////////////////////

	// Two stages, matching the capture and sum stages of partial_dot.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bias_d1 <= '0;
			bias_d2 <= '0;
			valid_d1 <= 1'b0;
			valid_d2 <= 1'b0;
		end
		else
		begin
			bias_d1 <= bias;
			bias_d2 <= bias_d1;
			valid_d1 <= in_valid;
			valid_d2 <= valid_d1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Full sum and activation
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		bias_scaled = neuron_pkg::acc_t'(bias_d2) <<< FRAC;
		sum_full = partial_low + partial_high + bias_scaled;

		// Round half up by dropping the low bits and adding back the first one dropped.
		rounded = {1'b0, sum_full[ACC_W-2:FRAC]} + ROUND_W'(sum_full[FRAC-1]);

		if (sum_full[ACC_W-1])
		begin
			act_out = '0;
		end
		else if (rounded > ROUND_W'(`NEURON_OUT_MAX))
		begin
			// Also catches a sum of 127.5 or more, which rounds to 128.
			act_out = neuron_pkg::result_t'(`NEURON_OUT_MAX);
		end
		else
		begin
			act_out = neuron_pkg::result_t'(rounded);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= valid_d2;
			if (valid_d2)
			begin
				out <= act_out;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	a_out_limit: assert property (
		@(posedge clk) disable iff (reset)
		out_valid |-> (out <= `NEURON_OUT_MAX)
	)
	else
		$error("relu_quantize: out %0d above limit", out);

	// No stale strobe may leak out of the delay line after reset.
	a_reset_quiet: assert property (
		@(posedge clk)
		reset |=> !out_valid
	)
	else
		$error("relu_quantize: out_valid set right after reset");

endmodule

// ==== rtl/neuron.sv ====
`timescale 1ns/1ps

`include "neuron_macros.svh"

module neuron
(
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  neuron_pkg::act_t [`NEURON_INPUTS-1:0] act,
	input  neuron_pkg::weight_t [`NEURON_INPUTS-1:0] weight,
	input  neuron_pkg::bias_t bias,
	output neuron_pkg::result_t out,
	output logic out_valid
);

	localparam int LOW_LANES = `NEURON_SPLIT;
	localparam int HIGH_LANES = `NEURON_INPUTS - `NEURON_SPLIT;

	neuron_pkg::acc_t partial_low;
	neuron_pkg::acc_t partial_high;

	//////////////////////////////////////////////////////////////////////
	// Dot product halves
	//////////////////////////////////////////////////////////////////////

	// The two halves run side by side with equal latency.
	partial_dot
	#(
		.LANES(LOW_LANES)
	)
	u_dot_low
	(
		.clk(clk),
		.reset(reset),
		.act(act[LOW_LANES-1:0]),
		.weight(weight[LOW_LANES-1:0]),
		.partial(partial_low)
	);

	partial_dot
	#(
		.LANES(HIGH_LANES)
	)
	u_dot_high
	(
		.clk(clk),
		.reset(reset),
		.act(act[`NEURON_INPUTS-1:LOW_LANES]),
		.weight(weight[`NEURON_INPUTS-1:LOW_LANES]),
		.partial(partial_high)
	);

	//////////////////////////////////////////////////////////////////////
	// Combine, bias and activate
	//////////////////////////////////////////////////////////////////////

	// Bias and strobe enter here straight from the ports.
	relu_quantize u_relu
	(
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.bias(bias),
		.partial_low(partial_low),
		.partial_high(partial_high),
		.out(out),
		.out_valid(out_valid)
	);

endmodule

// ==== tb/neuron_ref.svh ====
`ifndef NEURON_REF_SVH
`define NEURON_REF_SVH

//////////////////////////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////////////////////////

// Integer form of the neuron rule. Products and the bias share 12 fractional bits.
function automatic int neuron_model(
	input neuron_pkg::act_t [`NEURON_INPUTS-1:0] a,
	input neuron_pkg::weight_t [`NEURON_INPUTS-1:0] w,
	input neuron_pkg::bias_t b
);
	int sum;
	int scaled;
	int i;
	sum = int'(b) * 64;
	for (i = 0; i < `NEURON_INPUTS; i++)
	begin
		sum = sum + int'(a[i]) * int'(w[i]);
	end
	if (sum < 0)
	begin
		return 0;
	end
	scaled = sum / 64;
	// Half a step or more rounds up.
	if ((sum % 64) >= 32)
	begin
		scaled = scaled + 1;
	end
	if (scaled > `NEURON_OUT_MAX)
	begin
		scaled = `NEURON_OUT_MAX;
	end
	return scaled;
endfunction

//////////////////////////////////////////////////////////////////////
// Expected results in flight
//////////////////////////////////////////////////////////////////////

localparam int RING_DEPTH = 8;

int exp_value [RING_DEPTH];
int exp_cycle [RING_DEPTH];
string exp_name [RING_DEPTH];
int wr_count = 0;
int rd_count = 0;

task automatic record_expected(input string name, input int value, input int strobe_cycle);
	int slot;
	slot = wr_count % RING_DEPTH;
	exp_name[slot] = name;
	exp_value[slot] = value;
	exp_cycle[slot] = strobe_cycle;
	wr_count = wr_count + 1;
endtask

`endif

// ==== tb/tb_neuron.sv ====
`timescale 1ns/1ps

`include "neuron_macros.svh"

module tb_neuron;

	localparam int CLK_HALF = 20;
	localparam int RESET_CYCLES = 5;
	localparam int DIRECTED_VECTORS = 11;
	localparam int RANDOM_VECTORS = 300;
	localparam int MAX_GAP = 2;
	localparam int TIMEOUT_CYCLES =
		RESET_CYCLES + (DIRECTED_VECTORS + RANDOM_VECTORS) * (1 + MAX_GAP) + 100;

	logic clk;
	logic reset;
	logic in_valid;
	neuron_pkg::act_t [`NEURON_INPUTS-1:0] act;
	neuron_pkg::weight_t [`NEURON_INPUTS-1:0] weight;
	neuron_pkg::bias_t bias;
	neuron_pkg::result_t out;
	logic out_valid;

	neuron_pkg::act_t [`NEURON_INPUTS-1:0] vec_act;
	neuron_pkg::weight_t [`NEURON_INPUTS-1:0] vec_weight;
	neuron_pkg::bias_t vec_bias;
	logic [31:0] rng = 32'h7cfa;
	int cycle = 0;
	logic seen_valid = 1'b0;
	logic result_seen = 1'b0;

	`include "neuron_ref.svh"

	int pending;
	int rd_slot;
	int head_value;
	int head_cycle;

	assign pending = wr_count - rd_count;
	assign rd_slot = rd_count % RING_DEPTH;
	assign head_value = exp_value[rd_slot];
	assign head_cycle = exp_cycle[rd_slot];

	neuron u_neuron
	(
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.act(act),
		.weight(weight),
		.bias(bias),
		.out(out),
		.out_valid(out_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped on error.");
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic clear_vector();
		vec_act = '0;
		vec_weight = '0;
		vec_bias = '0;
	endtask

	task automatic send_vector(input string name);
		int expected;
		expected = neuron_model(vec_act, vec_weight, vec_bias);
		@(negedge clk);
		act = vec_act;
		weight = vec_weight;
		bias = vec_bias;
		in_valid = 1'b1;
		// The DUT samples this vector at the next rising edge, where cycle still reads this value.
		record_expected(name, expected, cycle);
	endtask

	task automatic hold_idle(input int cycles);
		repeat (cycles)
		begin
			@(negedge clk);
			in_valid = 1'b0;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Result tracking
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		seen_valid <= out_valid;
		if (out_valid === 1'b1)
		begin
			result_seen <= 1'b1;
		end
	end

	// A result checked at the last rising edge leaves the ring here.
	always @(negedge clk)
	begin
		if (seen_valid === 1'b1)
		begin
			rd_count <= rd_count + 1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	a_reset_quiet: assert property (@(posedge clk) (cycle != 0 && reset) |-> !out_valid)
	else
		report_failure("out_valid was set while reset was held.");

	a_reset_out: assert property (
		@(posedge clk) (cycle != 0 && !result_seen && !out_valid) |-> (out == '0))
	else
		report_failure("out was not zero before the first result.");

	a_no_orphan: assert property (
		@(posedge clk) disable iff (reset) out_valid |-> (pending != 0))
	else
		report_failure("out_valid came with no vector waiting for a result.");

	a_no_missing: assert property (
		@(posedge clk) disable iff (reset)
		(pending != 0 && cycle == head_cycle + `NEURON_LATENCY) |-> out_valid)
	else
		report_failure($sformatf("No result for test %s after %0d cycles.",
			exp_name[rd_slot], `NEURON_LATENCY));

	a_latency: assert property (
		@(posedge clk) disable iff (reset)
		(out_valid && pending != 0) |-> (cycle == head_cycle + `NEURON_LATENCY))
	else
		report_failure($sformatf("Result for test %s came %0d cycles after its strobe.",
			exp_name[rd_slot], cycle - head_cycle));

	a_value: assert property (
		@(posedge clk) disable iff (reset)
		(out_valid && pending != 0) |-> (int'(out) == head_value))
	else
		report_failure($sformatf("Mismatch test %s expected %0d actual %0d",
			exp_name[rd_slot], head_value, out));

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		report_failure("Timeout, the run did not finish in the allowed time.");
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int n;
		int i;
		int gap;
		reset = 1'b1;
		in_valid = 1'b0;
		act = '0;
		weight = '0;
		bias = '0;
		clear_vector();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		hold_idle(2);

		// Directed vectors go back to back.
		clear_vector();
		vec_weight = {`NEURON_INPUTS{8'sd45}};
		vec_bias = 8'sd37;
		send_vector("bias_pos");
		vec_bias = -8'sd20;
		send_vector("bias_neg");
		vec_bias = 8'sd127;
		send_vector("bias_max");
		clear_vector();
		vec_act[0] = -8'sd64;
		vec_weight[0] = 8'sd64;
		send_vector("relu_neg");
		vec_act = {`NEURON_INPUTS{8'sd127}};
		vec_weight = {`NEURON_INPUTS{8'sd127}};
		send_vector("sat_all_max");
		clear_vector();
		vec_act[0] = 8'sd64;
		vec_weight[0] = 8'sd64;
		vec_act[1] = 8'sd64;
		vec_weight[1] = 8'sd64;
		vec_act[2] = 8'sd1;
		vec_weight[2] = 8'sd1;
		send_vector("sat_above_2_13");
		clear_vector();
		vec_bias = 8'sd127;
		vec_act[0] = 8'sd32;
		vec_weight[0] = 8'sd1;
		send_vector("sat_round_up");
		vec_bias = 8'sd10;
		vec_act[0] = 8'sd31;
		send_vector("round_below_half");
		vec_act[0] = 8'sd32;
		send_vector("round_at_half");
		vec_act[0] = 8'sd33;
		send_vector("round_above_half");
		vec_bias = -8'sd1;
		vec_act[0] = 8'sd16;
		vec_weight[0] = 8'sd2;
		send_vector("relu_small_neg");
		hold_idle(1);

		for (n = 0; n < RANDOM_VECTORS; n++)
		begin
			for (i = 0; i < `NEURON_INPUTS; i++)
			begin
				rng = lcg_next(rng);
				vec_act[i] = rng[23:16];
				vec_weight[i] = rng[31:24];
				// Small activations keep some sums inside the output range.
				if (rng[9])
				begin
					vec_act[i] = vec_act[i] >>> 3;
				end
			end
			rng = lcg_next(rng);
			vec_bias = rng[23:16];
			gap = rng[31:28] % (MAX_GAP + 1);
			send_vector($sformatf("random_%0d", n));
			hold_idle(gap);
		end

		hold_idle(`NEURON_LATENCY + 3);
		if (pending == 0)
		begin
			$display("Result: PASSED");
			$finish;
		end
		else
		begin
			report_failure($sformatf("%0d results never appeared.", pending));
		end
	end

endmodule

// ==== filelist.f ====
+incdir+rtl
+incdir+tb
rtl/neuron_pkg.sv
rtl/partial_dot.sv
rtl/relu_quantize.sv
rtl/neuron.sv
tb/tb_neuron.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the neuron testbench with Verilator and runs it.
# The exit status is 0 only when the run passes.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_neuron
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f \
	--top-module tb_neuron \
	-Mdir "$BUILD_DIR" \
	-o "$SIM_BIN"
build_status=$?
if [ "$build_status" -ne 0 ]; then
	echo "Build failed with status $build_status"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q "Result: FAILED" "$LOG_FILE"; then
	echo "Simulation reported a failure"
	exit 1
fi

if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if ! grep -q "Result: PASSED" "$LOG_FILE"; then
	echo "Simulation ended without a result"
	exit 1
fi

echo "Simulation passed"
exit 0
